//--- mips16_exec.f
+incdir+include
logic/mips16_pkg.sv
logic/instr_fetch.sv
logic/decode_exec.sv
logic/reg_file.sv
logic/exe_wb.sv
logic/mips16_core.sv
tests/clock_gen.sv
tests/mips16_core_tb.sv

//--- Makefile
TOP := mips16_core_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f mips16_exec.f --top-module $(TOP) -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tests/mips16_core_tb.sv
`default_nettype none

module mips16_core_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import mips16_pkg::*;

	localparam int rom_words = 512;
	localparam int max_exp = 1024;
	localparam instr_t nop_word = {op_nop, 11'b0};

	logic clk;
	logic pclk;
	pc_t instr_addr;
	instr_t instr_data;
	wb_pkt_t wb_out;
	reg_value_t sp_out;

	instr_t rom [rom_words];
	int prog_len = 0;
	bit prog_built = 1'b0;

	// expected commits in program order, kind 1 means an SP write
	bit exp_kind [max_exp];
	reg_addr_t exp_addr [max_exp];
	reg_value_t exp_data [max_exp];
	pc_t exp_target [max_exp];
	int exp_count = 0;
	int br_count = 0;

	int ci = 0;          // next expected commit
	int ri = 0;          // next expected redirect
	int cyc_out = 0;     // cycles since reset release
	pc_t prev_addr = '0;
	logic prev_redir = 1'b0;
	pc_t last_target = '0;
	reg_value_t sp_ref = '0;

	clock_gen u_clk (.clk(clk), .pclk(pclk));

	mips16_core DUT (
		.clk        (clk),
		.pclk       (pclk),
		.instr_addr (instr_addr),
		.instr_data (instr_data),
		.wb_out     (wb_out),
		.sp_out     (sp_out)
	);

	assign instr_data = rom[instr_addr[8:0]]; // memory answers in the same cycle

	task automatic fail_and_stop();
		$display("Regression failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_mismatch(string sig, logic [15:0] expected, logic [15:0] actual);
		$display("FAIL time=%0t signal=%s expected=%h actual=%h", $time, sig, expected, actual);
		fail_and_stop();
	endtask

	task automatic report_problem(string why);
		$display("ERROR time=%0t %s", $time, why);
		fail_and_stop();
	endtask

	task automatic emit(instr_t word);
		rom[prog_len] = word;
		prog_len++;
	endtask

	function automatic reg_value_t sext8(logic [7:0] v);
		return {{8{v[7]}}, v};
	endfunction

	// every instruction is followed by a NOP, so each consumer sits one slot behind
	task automatic build_program();
		reg_addr_t rx;
		reg_addr_t ry;
		reg_addr_t rz;
		logic [7:0] imm;
		logic [1:0] f;
		int sel;
		bit take;
		take = 1'b1;
		for (int a = 0; a < rom_words; a++) begin
			rom[a] = {7'b0000000, 9'(a)}; // opcode 00000 is unused
		end
		for (int r = 0; r < num_regs; r++) begin
			emit({op_li, 3'(r), 8'($urandom)});
			emit(nop_word);
		end
		for (int it = 0; it < 36; it++) begin
			rx = 3'($urandom);
			ry = 3'($urandom);
			rz = 3'($urandom);
			imm = 8'($urandom);
			sel = it % 11; // templates in a fixed rotation
			case (sel)
				0: emit({op_li, rx, imm});
				1: emit({op_addiu, rx, it[0], imm[6:0]}); // alternate signs
				2: emit({op_move, rx, ry, 5'b00000});
				3: emit({op_addu, rx, ry, rz, 2'b01});
				4: emit({op_sll, rx, ry, imm[2:0], 2'b00});
				5: begin
					f = 2'(1 + $urandom % 3);
					emit({op_sll, rx, ry, imm[2:0], f});
					f = (imm[7:6] == 2'b01) ? 2'b00 : imm[7:6];
					emit({op_addu, rx, ry, rz, f});
				end
				6: emit({op_mtsp, 3'b100, ry, 5'b00000});
				7: emit({5'b10000, imm, rx});
				8: emit(nop_word);
				default: begin
					emit({op_li, rx, take ? (imm | 8'h01) : 8'h00});
					emit(nop_word);
					emit({op_bnez, rx, 8'd3}); // target is the NOP four slots on
					emit({op_li, ry, imm});
					emit({op_li, rz, ~imm});
					emit({op_li, rx, imm ^ 8'h5a});
					emit(nop_word);
					take = ~take;
				end
			endcase
			emit(nop_word);
		end
	endtask

	// architectural walk of the program, taken branches included
	task automatic run_model();
		reg_value_t regs_m [num_regs];
		pc_t pc;
		instr_t w;
		reg_addr_t rx;
		reg_addr_t ry;
		bit do_wr;
		bit do_sp;
		reg_addr_t wa;
		reg_value_t wd;
		for (int r = 0; r < num_regs; r++) begin
			regs_m[r] = '0;
		end
		pc = '0;
		while (int'(pc) < prog_len) begin
			w = rom[pc[8:0]];
			rx = w[10:8];
			ry = w[7:5];
			do_wr = 1'b0;
			do_sp = 1'b0;
			wa = rx;
			wd = '0;
			pc = pc + 16'd1;
			case (w[15:11])
				op_li: begin
					do_wr = 1'b1;
					wd = {8'h00, w[7:0]};
				end
				op_addiu: begin
					do_wr = 1'b1;
					wd = regs_m[rx] + sext8(w[7:0]);
				end
				op_sll: begin
					do_wr = (w[1:0] == 2'b00);
					wd = regs_m[ry] << ((w[4:2] == 3'd0) ? 4'd8 : {1'b0, w[4:2]});
				end
				op_addu: begin
					do_wr = (w[1:0] == 2'b01);
					wa = w[4:2];
					wd = regs_m[rx] + regs_m[ry];
				end
				op_move: begin
					do_wr = (w[4:0] == 5'b00000);
					wd = regs_m[ry];
				end
				op_mtsp: begin
					do_sp = (rx == 3'b100);
					wd = regs_m[ry];
				end
				op_bnez: begin
					if (regs_m[rx] != '0) begin
						pc = pc + sext8(w[7:0]);
						exp_target[br_count] = pc;
						br_count++;
					end
				end
				default: do_wr = 1'b0;
			endcase
			if (do_wr || do_sp) begin
				exp_kind[exp_count] = do_sp;
				exp_addr[exp_count] = wa;
				exp_data[exp_count] = wd;
				exp_count++;
			end
			if (do_wr) regs_m[wa] = wd;
		end
	endtask

	// progress trackers, read at negedge by the checks
	always @(posedge clk) begin
		cyc_out <= pclk ? 0 : cyc_out + 1;
		prev_addr <= instr_addr;
		prev_redir <= DUT.redirect.pc_switch_ctrl;
		if (wb_out.write_reg_ctrl || wb_out.wrsp) ci <= ci + 1;
		if (wb_out.wrsp && ci < exp_count) sp_ref <= exp_data[ci];
		if (DUT.redirect.pc_switch_ctrl) begin
			if (ri < br_count) last_target <= exp_target[ri];
			ri <= ri + 1;
		end
	end

	reset_quiet: assert property (@(negedge clk)
		(pclk || cyc_out == 0) |-> !(wb_out.write_reg_ctrl || wb_out.wrsp))
		else report_problem("commit pulse during or right after reset");
	reset_addr: assert property (@(negedge clk) (pclk || cyc_out == 0) |-> instr_addr == '0)
		else report_mismatch("instr_addr", 16'h0000, instr_addr);
	step_addr: assert property (@(negedge clk)
		(!pclk && cyc_out != 0 && !prev_redir) |-> instr_addr == prev_addr + 16'd1)
		else report_mismatch("instr_addr", prev_addr + 16'd1, instr_addr);
	redirect_known: assert property (@(negedge clk)
		DUT.redirect.pc_switch_ctrl |-> ri < br_count)
		else report_problem("redirect although no taken branch was expected");
	redirect_addr: assert property (@(negedge clk) (!pclk && prev_redir) |-> instr_addr == last_target)
		else report_mismatch("instr_addr", last_target, instr_addr);
	wr_known: assert property (@(negedge clk)
		wb_out.write_reg_ctrl |-> (ci < exp_count && !exp_kind[ci]))
		else report_problem("register write that the program does not produce");
	wr_addr: assert property (@(negedge clk) (wb_out.write_reg_ctrl && ci < exp_count)
		|-> wb_out.write_reg_addr == exp_addr[ci])
		else report_mismatch("wb_out.write_reg_addr", 16'(exp_addr[ci]),
			16'(wb_out.write_reg_addr));
	wr_data: assert property (@(negedge clk) (wb_out.write_reg_ctrl && ci < exp_count)
		|-> wb_out.write_reg_data == exp_data[ci])
		else report_mismatch("wb_out.write_reg_data", exp_data[ci], wb_out.write_reg_data);
	sp_known: assert property (@(negedge clk) wb_out.wrsp |-> (ci < exp_count && exp_kind[ci]))
		else report_problem("SP write that the program does not produce");
	sp_data: assert property (@(negedge clk) (wb_out.wrsp && ci < exp_count)
		|-> wb_out.sp_reg_data == exp_data[ci])
		else report_mismatch("wb_out.sp_reg_data", exp_data[ci], wb_out.sp_reg_data);
	sp_value: assert property (@(negedge clk) !pclk |-> sp_out == sp_ref)
		else report_mismatch("sp_out", sp_ref, sp_out);

	initial begin
		void'($urandom(14));
		build_program();
		run_model();
		prog_built = 1'b1;
		wait (!pclk);
		wait (ci == exp_count && ri == br_count);
		repeat (10) @(negedge clk); // catch any late extra commit
		if (ci == exp_count && ri == br_count) begin
			$display("Regression passed");
			$finish;
		end else begin
			report_problem("commits continued past the end of the program");
		end
	end

	// worst case four cycles per instruction plus reset
	initial begin
		wait (prog_built);
		#(prog_len * 4 * 40 + 5 * 40);
		report_problem("watchdog expired, the pipeline stopped committing");
	end

endmodule

`default_nettype wire

//--- tests/clock_gen.sv
`default_nettype none

module clock_gen (
	output logic clk,
	output logic pclk
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	// reset held for five rising edges
	initial begin
		pclk = 1'b1;
		repeat (5) @(posedge clk);
		pclk <= 1'b0;
	end

endmodule

`default_nettype wire

//--- logic/mips16_core.sv
`default_nettype none

module mips16_core (
	input  logic                   clk,
	input  logic                   pclk,
	output mips16_pkg::pc_t        instr_addr,
	input  mips16_pkg::instr_t     instr_data,
	output mips16_pkg::wb_pkt_t    wb_out,
	output mips16_pkg::reg_value_t sp_out
);
	import mips16_pkg::*;

	redirect_t  redirect;
	exe_pkt_t   exe_pkt;
	reg_addr_t  rd_addr_a;
	reg_addr_t  rd_addr_b;
	reg_value_t rd_data_a;
	reg_value_t rd_data_b;

	instr_fetch u_fetch (
		.clk        (clk),
		.pclk       (pclk),
		.redirect   (redirect),
		.instr_addr (instr_addr)
	);

	// decode sees the fetch address as its pc
	decode_exec u_decode (
		.clk        (clk),
		.pclk       (pclk),
		.instr_data (instr_data),
		.pc         (instr_addr),
		.redirect   (redirect),
		.rd_addr_a  (rd_addr_a),
		.rd_addr_b  (rd_addr_b),
		.rd_data_a  (rd_data_a),
		.rd_data_b  (rd_data_b),
		.exe_pkt    (exe_pkt)
	);

	reg_file u_regs (
		.clk       (clk),
		.pclk      (pclk),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.wb        (wb_out),
		.sp        (sp_out)
	);

	exe_wb u_exe_wb (
		.clk      (clk),
		.pclk     (pclk),
		.exe_pkt  (exe_pkt),
		.wb       (wb_out), // commit bus, also observed outside
		.redirect (redirect)
	);

endmodule

`default_nettype wire

//--- logic/exe_wb.sv
`default_nettype none

module exe_wb (
	input  logic                  clk,
	input  logic                  pclk,
	input  mips16_pkg::exe_pkt_t  exe_pkt,
	output mips16_pkg::wb_pkt_t   wb,
	output mips16_pkg::redirect_t redirect
);
	import mips16_pkg::*;

	opcode_t opcode;
	logic    reg_wr_d;
	logic    sp_wr_d;
	logic    branch_d;

	logic       write_reg_ctrl;
	logic       wrsp;
	logic       pc_switch_ctrl;
	reg_addr_t  write_reg_addr;
	reg_value_t write_reg_data;
	reg_value_t sp_reg_data;
	pc_t        new_pc;

	assign opcode = exe_pkt.opn[15:11];

	// decide what this packet commits
	always_comb begin
		reg_wr_d = 1'b0;
		sp_wr_d  = 1'b0;
		branch_d = 1'b0;
		// packet right behind a taken branch is the first shadow slot
		if (exe_pkt.valid && !pc_switch_ctrl) begin
			case (opcode)
				op_li, op_addiu: reg_wr_d = 1'b1;
				op_sll:  reg_wr_d = (exe_pkt.opn[1:0] == funct_sll);
				op_addu: reg_wr_d = (exe_pkt.opn[1:0] == funct_addu);
				op_move: reg_wr_d = (exe_pkt.opn[4:0] == move_low_field);
				op_mtsp: sp_wr_d  = (exe_pkt.opn[10:8] == funct_mtsp);
				op_bnez: branch_d = exe_pkt.alu_flag; // not taken, no pulse
				default: begin
					reg_wr_d = 1'b0; // NOP and anything unknown
				end
			endcase
		end
	end

	// strobes last one cycle
	always_ff @(posedge clk or posedge pclk) begin
		if (pclk) begin
			write_reg_ctrl <= 1'b0;
			wrsp           <= 1'b0;
			pc_switch_ctrl <= 1'b0;
		end else begin
			write_reg_ctrl <= reg_wr_d;
			wrsp           <= sp_wr_d;
			pc_switch_ctrl <= branch_d;
		end
	end

	always_ff @(posedge clk) begin
		write_reg_addr <= exe_pkt.reg_addr;
		write_reg_data <= exe_pkt.alu_res;
		sp_reg_data    <= exe_pkt.alu_res;
		new_pc         <= exe_pkt.pc_input + exe_pkt.alu_res; // pc+1 plus offset
	end

	assign wb = '{
		write_reg_ctrl: write_reg_ctrl,
		write_reg_addr: write_reg_addr,
		write_reg_data: write_reg_data,
		wrsp:           wrsp,
		sp_reg_data:    sp_reg_data
	};

	assign redirect = '{pc_switch_ctrl: pc_switch_ctrl, new_pc: new_pc};

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`default_nettype none

module reg_file (
	input  logic                   clk,
	input  logic                   pclk,
	input  mips16_pkg::reg_addr_t  rd_addr_a,
	input  mips16_pkg::reg_addr_t  rd_addr_b,
	output mips16_pkg::reg_value_t rd_data_a,
	output mips16_pkg::reg_value_t rd_data_b,
	input  mips16_pkg::wb_pkt_t    wb,
	output mips16_pkg::reg_value_t sp
);
	import mips16_pkg::*;

	reg_value_t regs [num_regs];
	reg_value_t sp_q;

	always_ff @(posedge clk or posedge pclk) begin
		if (pclk) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
			sp_q <= '0;
		end else begin
			if (wb.write_reg_ctrl) begin
				regs[wb.write_reg_addr] <= wb.write_reg_data;
			end
			if (wb.wrsp) begin
				sp_q <= wb.sp_reg_data;
			end
		end
	end

	// write-through, so a reader one slot behind the producer sees the result
	assign rd_data_a = (wb.write_reg_ctrl && (wb.write_reg_addr == rd_addr_a)) ?
		wb.write_reg_data : regs[rd_addr_a];
	assign rd_data_b = (wb.write_reg_ctrl && (wb.write_reg_addr == rd_addr_b)) ?
		wb.write_reg_data : regs[rd_addr_b];

	assign sp = sp_q;

endmodule

`default_nettype wire

//--- logic/decode_exec.sv
`default_nettype none

module decode_exec (
	input  logic                   clk,
	input  logic                   pclk,
	input  mips16_pkg::instr_t     instr_data,
	input  mips16_pkg::pc_t        pc,
	input  mips16_pkg::redirect_t  redirect,
	output mips16_pkg::reg_addr_t  rd_addr_a,
	output mips16_pkg::reg_addr_t  rd_addr_b,
	input  mips16_pkg::reg_value_t rd_data_a,
	input  mips16_pkg::reg_value_t rd_data_b,
	output mips16_pkg::exe_pkt_t   exe_pkt
);
	import mips16_pkg::*;

	opcode_t    opcode;
	reg_addr_t  rx;
	reg_addr_t  ry;
	reg_addr_t  rz;
	logic [7:0] imm8;
	logic [2:0] imm3;
	logic [3:0] shamt;
	reg_value_t simm;

	exe_pkt_t pkt_d;
	exe_pkt_t pkt_q;
	logic     valid_q;

	// instruction fields
	assign opcode = instr_data[15:11];
	assign rx     = instr_data[10:8];
	assign ry     = instr_data[7:5];
	assign rz     = instr_data[4:2];
	assign imm8   = instr_data[7:0];
	assign imm3   = instr_data[4:2];

	// shift field of 0 encodes a shift by 8
	assign shamt = (imm3 == 3'd0) ? 4'd8 : {1'b0, imm3};
	assign simm  = {{8{imm8[7]}}, imm8};

	// port a always reads rx, port b reads ry
	assign rd_addr_a = rx;
	assign rd_addr_b = ry;

	always_comb begin
		pkt_d.valid    = ~redirect.pc_switch_ctrl; // flush on a taken branch
		pkt_d.opn      = instr_data;
		pkt_d.reg_addr = rx;
		pkt_d.alu_flag = 1'b0;
		pkt_d.pc_input = pc + pc_t'(1);
		case (opcode)
			op_li: begin
				pkt_d.alu_res = {8'h00, imm8}; // zero extended
			end
			op_addiu: begin
				pkt_d.alu_res = rd_data_a + simm;
			end
			op_sll: begin
				pkt_d.alu_res = rd_data_b << shamt;
			end
			op_addu: begin
				pkt_d.reg_addr = rz; // three register form
				pkt_d.alu_res  = rd_data_a + rd_data_b;
			end
			op_move: begin
				pkt_d.alu_res = rd_data_b;
			end
			op_bnez: begin
				pkt_d.alu_res  = simm; // branch offset
				pkt_d.alu_flag = (rd_data_a != '0);
			end
			op_mtsp: begin
				pkt_d.alu_res = rd_data_b; // new SP value
			end
			default: begin
				pkt_d.alu_res = '0; // NOP or unknown opcode, exe_wb ignores it
			end
		endcase
	end

	always_ff @(posedge clk or posedge pclk) begin
		if (pclk) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= pkt_d.valid;
		end
	end

	// execute packet payload
	always_ff @(posedge clk) begin
		pkt_q <= pkt_d;
	end

	always_comb begin
		exe_pkt       = pkt_q;
		exe_pkt.valid = valid_q;
	end

endmodule

`default_nettype wire

//--- logic/instr_fetch.sv
`default_nettype none

module instr_fetch (
	input  logic                  clk,
	input  logic                  pclk,
	input  mips16_pkg::redirect_t redirect,
	output mips16_pkg::pc_t       instr_addr
);
	import mips16_pkg::*;

	pc_t pc;
	pc_t pc_next;

	// a redirect wins over the sequential step
	always_comb begin
		if (redirect.pc_switch_ctrl) begin
			pc_next = redirect.new_pc;
		end else begin
			pc_next = pc + pc_t'(1); // word addressed memory
		end
	end

	always_ff @(posedge clk or posedge pclk) begin
		if (pclk) begin
			pc <= '0;
		end else begin
			pc <= pc_next;
		end
	end

	// memory answers in the same cycle
	assign instr_addr = pc;

endmodule

`default_nettype wire

//--- logic/mips16_pkg.sv
`default_nettype none

package mips16_pkg;

	localparam int num_regs = 8; // general registers r0..r7

	typedef logic [2:0]  reg_addr_t;
	typedef logic [15:0] reg_value_t;
	typedef logic [15:0] pc_t;
	typedef logic [15:0] instr_t;
	typedef logic [4:0]  opcode_t; // instr[15:11]

	`include "mips16_opcodes.svh"

	// decode/execute result, one per fetched instruction
	typedef struct packed {
		logic       valid;
		instr_t     opn;      // raw instruction, re-decoded in exe_wb
		reg_addr_t  reg_addr; // destination register
		reg_value_t alu_res;
		logic       alu_flag; // BNEZ condition
		pc_t        pc_input; // address of the next instruction
	} exe_pkt_t;

	// commit bus towards the register file
	typedef struct packed {
		logic       write_reg_ctrl;
		reg_addr_t  write_reg_addr;
		reg_value_t write_reg_data;
		logic       wrsp;
		reg_value_t sp_reg_data;
	} wb_pkt_t;

	// taken branch, also flushes the younger instructions
	typedef struct packed {
		logic pc_switch_ctrl;
		pc_t  new_pc;
	} redirect_t;

endpackage

`default_nettype wire

//--- include/mips16_opcodes.svh
`ifndef MIPS16_OPCODES_SVH
`define MIPS16_OPCODES_SVH

// major opcodes, instr[15:11]
localparam logic [4:0] op_nop   = 5'b00001;
localparam logic [4:0] op_bnez  = 5'b00101;
localparam logic [4:0] op_sll   = 5'b00110;
localparam logic [4:0] op_addiu = 5'b01001;
localparam logic [4:0] op_mtsp  = 5'b01100;
localparam logic [4:0] op_li    = 5'b01101;
localparam logic [4:0] op_move  = 5'b01111;
localparam logic [4:0] op_addu  = 5'b11100;

// function fields in the low bits of shift and rrr formats
localparam logic [1:0] funct_sll  = 2'b00; // instr[1:0]
localparam logic [1:0] funct_addu = 2'b01; // instr[1:0]

// MTSP shares its major opcode with the other SP ops
localparam logic [2:0] funct_mtsp = 3'b100; // instr[10:8]

// MOVE carries zeros in its low field
localparam logic [4:0] move_low_field = 5'b00000;

`endif
